// ==== hw/air_rx_ctrl.sv ====
`timescale 1ns/10ps
`include "rf_ctrl_macros.svh"

module air_rx_ctrl import rf_link_pkg::*, rf_fsm_pkg::*; (
    input  logic     mode0_clk,
    input  logic     rst_n,
    input  uart_rx_t node_rx,
    input  logic     mcu_tx_idle,
    output uart_tx_t mcu_tx,
    output logic     busy
);

    rx_state_t   state;
    rx_state_t   state_nxt;
    rf_byte_t    fifo_rd_data;
    logic        fifo_empty;
    logic        hold_done;
    logic        issue;
    logic        start_q;
    rf_byte_t    data_q;

    byte_fifo #(
        .DEPTH (`RF_FIFO_DEPTH)
    ) i_fifo (
        .mode0_clk (mode0_clk),
        .rst_n     (rst_n),
        .wr        (node_rx.valid),
        .wr_data   (node_rx.data),
        .rd        (issue),
        .rd_data   (fifo_rd_data),
        .count     (),
        .empty     (fifo_empty)
    );

    // Hold time counts only in RX_HOLD and clears on leaving it
    wait_timer #(
        .LIMIT (`RF_RX_HOLD_CYCLES)
    ) i_hold_timer (
        .mode0_clk (mode0_clk),
        .rst_n     (rst_n),
        .enable    (state == RX_HOLD),
        .restart   (1'b0),
        .done      (hold_done)
    );

    always_comb begin
        state_nxt = state;
        case (state)
            RX_IDLE: begin
                if (!fifo_empty) begin
                    state_nxt = RX_HOLD;
                end
            end
            RX_HOLD: begin
                if (hold_done) begin
                    state_nxt = RX_SEND;
                end
            end
            RX_SEND: begin
                if (fifo_empty && !start_q) begin
                    state_nxt = RX_DRAIN;
                end
            end
            RX_DRAIN: begin
                // Last byte still shifting out of the MCU UART
                if (mcu_tx_idle) begin
                    state_nxt = RX_IDLE;
                end
            end
            default: state_nxt = RX_IDLE;
        endcase
    end

    always_ff @(posedge mode0_clk or negedge rst_n) begin
        if (!rst_n) begin
            state <= RX_IDLE;
        end else begin
            state <= state_nxt;
        end
    end

    // Same start rule as the air side
    assign issue = (state == RX_SEND) && mcu_tx_idle && !start_q && !fifo_empty;

    always_ff @(posedge mode0_clk or negedge rst_n) begin
        if (!rst_n) begin
            start_q <= 1'b0;
        end else begin
            start_q <= issue;
        end
    end

    always_ff @(posedge mode0_clk) begin
        if (issue) begin
            data_q <= fifo_rd_data;
        end
    end

    assign mcu_tx = '{start: start_q, data: data_q};
    assign busy   = (state != RX_IDLE);

endmodule

// ==== hw/air_tx_ctrl.sv ====
`timescale 1ns/10ps
`include "rf_ctrl_macros.svh"

module air_tx_ctrl import rf_link_pkg::*, rf_fsm_pkg::*; (
    input  logic     mode0_clk,
    input  logic     rst_n,
    input  uart_rx_t mcu_rx,
    input  logic     node_tx_idle,
    output uart_tx_t node_tx,
    output logic     busy
);

    localparam fifo_count_t THRESHOLD = fifo_count_t'(`RF_TX_THRESHOLD);

    tx_state_t   state;
    tx_state_t   state_nxt;
    rf_byte_t    fifo_rd_data;
    fifo_count_t fifo_count;
    logic        fifo_empty;
    logic        idle_done;
    logic        issue;
    logic        start_q;
    rf_byte_t    data_q;

    byte_fifo #(
        .DEPTH (`RF_FIFO_DEPTH)
    ) i_fifo (
        .mode0_clk (mode0_clk),
        .rst_n     (rst_n),
        .wr        (mcu_rx.valid),
        .wr_data   (mcu_rx.data),
        .rd        (issue),
        .rd_data   (fifo_rd_data),
        .count     (fifo_count),
        .empty     (fifo_empty)
    );

    // Line idle detector, every new MCU byte starts it over
    wait_timer #(
        .LIMIT (`RF_TX_IDLE_CYCLES)
    ) i_idle_timer (
        .mode0_clk (mode0_clk),
        .rst_n     (rst_n),
        .enable    (state == TX_COLLECT),
        .restart   (mcu_rx.valid),
        .done      (idle_done)
    );

    always_comb begin
        state_nxt = state;
        case (state)
            TX_IDLE: begin
                if (!fifo_empty) begin
                    state_nxt = TX_COLLECT;
                end
            end
            TX_COLLECT: begin
                // Full packet or a quiet line both send
                if ((fifo_count >= THRESHOLD) || idle_done) begin
                    state_nxt = TX_SEND;
                end
            end
            TX_SEND: begin
                if (fifo_empty && !start_q) begin
                    state_nxt = TX_IDLE;
                end
            end
            default: state_nxt = TX_IDLE;
        endcase
    end

    always_ff @(posedge mode0_clk or negedge rst_n) begin
        if (!rst_n) begin
            state <= TX_IDLE;
        end else begin
            state <= state_nxt;
        end
    end

    // One start per free UART slot, the pop happens on the same edge
    assign issue = (state == TX_SEND) && node_tx_idle && !start_q && !fifo_empty;

    always_ff @(posedge mode0_clk or negedge rst_n) begin
        if (!rst_n) begin
            start_q <= 1'b0;
        end else begin
            start_q <= issue;
        end
    end

    always_ff @(posedge mode0_clk) begin
        if (issue) begin
            data_q <= fifo_rd_data;
        end
    end

    assign node_tx = '{start: start_q, data: data_q};
    assign busy    = (state != TX_IDLE);

endmodule

// ==== hw/byte_fifo.sv ====
`timescale 1ns/10ps
`include "rf_ctrl_macros.svh"

module byte_fifo import rf_link_pkg::*; #(
    parameter int DEPTH = `RF_FIFO_DEPTH
) (
    input  logic        mode0_clk,
    input  logic        rst_n,
    input  logic        wr,
    input  rf_byte_t    wr_data,
    input  logic        rd,
    output rf_byte_t    rd_data,
    output fifo_count_t count,
    output logic        empty
);

    localparam int PTR_W = (DEPTH > 1) ? $clog2(DEPTH) : 1;
    localparam logic [PTR_W-1:0] LAST_PTR = PTR_W'(DEPTH - 1);
    localparam fifo_count_t FULL_COUNT = fifo_count_t'(DEPTH);

    rf_byte_t         mem [DEPTH];
    logic [PTR_W-1:0] wr_ptr;
    logic [PTR_W-1:0] rd_ptr;
    logic             full;
    logic             do_wr;
    logic             do_rd;

    assign empty = (count == '0);
    assign full  = (count == FULL_COUNT);

    // Writes into a full buffer are lost
    assign do_wr = wr && !full;
    assign do_rd = rd && !empty;

    // Head entry is always visible
    assign rd_data = mem[rd_ptr];

    always_ff @(posedge mode0_clk) begin
        if (do_wr) begin
            mem[wr_ptr] <= wr_data;
        end
    end

    always_ff @(posedge mode0_clk or negedge rst_n) begin
        if (!rst_n) begin
            wr_ptr <= '0;
            rd_ptr <= '0;
            count  <= '0;
        end else begin
            if (do_wr) begin
                wr_ptr <= (wr_ptr == LAST_PTR) ? '0 : wr_ptr + 1'b1;
            end
            if (do_rd) begin
                rd_ptr <= (rd_ptr == LAST_PTR) ? '0 : rd_ptr + 1'b1;
            end
            // Push and pop together leave the count alone
            case ({do_wr, do_rd})
                2'b10:   count <= count + 1'b1;
                2'b01:   count <= count - 1'b1;
                default: count <= count;
            endcase
        end
    end

endmodule

// ==== hw/rf_ctrl_macros.svh ====
`ifndef RF_CTRL_MACROS_SVH
`define RF_CTRL_MACROS_SVH

// Width of one UART byte
`define RF_DATA_W 8

// Entries in each path buffer
`define RF_FIFO_DEPTH 512

// Buffered bytes that start an air burst on their own
`define RF_TX_THRESHOLD 58

// Quiet MCU line length that flushes a partial packet
`define RF_TX_IDLE_CYCLES 64

// Delay after entering hold before air data goes to the MCU
`define RF_RX_HOLD_CYCLES 32

`endif

// ==== hw/rf_fsm_pkg.sv ====
package rf_fsm_pkg;

    // MCU to air path
    typedef enum logic [1:0] {
        TX_IDLE    = 2'd0,
        TX_COLLECT = 2'd1,
        TX_SEND    = 2'd2
    } tx_state_t;

    // Air to MCU path
    typedef enum logic [1:0] {
        RX_IDLE  = 2'd0,
        RX_HOLD  = 2'd1,
        RX_SEND  = 2'd2,
        RX_DRAIN = 2'd3
    } rx_state_t;

endpackage

// ==== hw/rf_link_pkg.sv ====
`include "rf_ctrl_macros.svh"

package rf_link_pkg;

    // One data byte on either UART
    typedef logic [`RF_DATA_W-1:0] rf_byte_t;

    // Occupancy, 0 up to and including full depth
    typedef logic [$clog2(`RF_FIFO_DEPTH + 1)-1:0] fifo_count_t;

    // Received byte, valid pulses once per byte
    typedef struct packed {
        logic     valid;
        rf_byte_t data;
    } uart_rx_t;

    // Byte to send, start is a one-cycle request
    typedef struct packed {
        logic     start;
        rf_byte_t data;
    } uart_tx_t;

endpackage

// ==== hw/rf_transceiver_ctrl.sv ====
`timescale 1ns/10ps

module rf_transceiver_ctrl import rf_link_pkg::*; (
    input  logic     mode0_clk,
    input  logic     rst_n,
    input  uart_rx_t mcu_rx,
    output uart_tx_t mcu_tx,
    input  logic     mcu_tx_idle,
    input  uart_rx_t node_rx,
    output uart_tx_t node_tx,
    input  logic     node_tx_idle,
    output logic     aux
);

    logic tx_busy;
    logic rx_busy;

    // MCU bytes out over the air
    air_tx_ctrl i_air_tx (
        .mode0_clk    (mode0_clk),
        .rst_n        (rst_n),
        .mcu_rx       (mcu_rx),
        .node_tx_idle (node_tx_idle),
        .node_tx      (node_tx),
        .busy         (tx_busy)
    );

    // Air bytes back to the MCU
    air_rx_ctrl i_air_rx (
        .mode0_clk   (mode0_clk),
        .rst_n       (rst_n),
        .node_rx     (node_rx),
        .mcu_tx_idle (mcu_tx_idle),
        .mcu_tx      (mcu_tx),
        .busy        (rx_busy)
    );

    // High only with both paths idle
    assign aux = ~tx_busy & ~rx_busy;

endmodule

// ==== hw/wait_timer.sv ====
`timescale 1ns/10ps

module wait_timer #(
    parameter int LIMIT = 16
) (
    input  logic mode0_clk,
    input  logic rst_n,
    input  logic enable,
    input  logic restart,
    output logic done
);

    localparam int CNT_W = $clog2(LIMIT + 1);
    localparam logic [CNT_W-1:0] LIMIT_CNT = CNT_W'(LIMIT);

    logic [CNT_W-1:0] cnt;

    // Saturates at the limit until cleared
    always_ff @(posedge mode0_clk or negedge rst_n) begin
        if (!rst_n) begin
            cnt <= '0;
        end else if (restart || !enable) begin
            cnt <= '0;
        end else if (cnt != LIMIT_CNT) begin
            cnt <= cnt + 1'b1;
        end
    end

    assign done = (cnt == LIMIT_CNT);

endmodule

// ==== rf_transceiver_ctrl.f ====
+incdir+hw
hw/rf_link_pkg.sv
hw/rf_fsm_pkg.sv
hw/byte_fifo.sv
hw/wait_timer.sv
hw/air_tx_ctrl.sv
hw/air_rx_ctrl.sv
hw/rf_transceiver_ctrl.sv
tb/tb_rf_transceiver_ctrl.sv

// ==== run_sim.sh ====
#!/bin/sh
# Build and run the testbench with Verilator

TOP=tb_rf_transceiver_ctrl

cd "$(dirname "$0")" || exit 1

verilator --binary --top-module "$TOP" -f rf_transceiver_ctrl.f -o "V$TOP"
status=$?
if [ $status -ne 0 ]; then
    echo "Verilator build failed with status $status"
    exit 1
fi

out=$("./obj_dir/V$TOP" 2>&1)
status=$?
printf '%s\n' "$out"
if [ $status -ne 0 ]; then
    echo "Simulation exited with status $status"
    exit 1
fi

if printf '%s\n' "$out" | grep -qx "TESTS PASSED"; then
    exit 0
fi
echo "Pass message not found in simulation output"
exit 1

// ==== tb/tb_rf_transceiver_ctrl.sv ====
`timescale 1ns/10ps
`include "rf_ctrl_macros.svh"

module tb_rf_transceiver_ctrl import rf_link_pkg::*; ();

    localparam int DIR_AIR  = 0;
    localparam int DIR_MCU  = 1;
    localparam int DIR_BOTH = 2;
    localparam int NUM_ROWS = 4;
    localparam int UART_BYTE_CYCLES = 10;
    localparam logic [31:0] LFSR_SEED = 32'h3e49d94f;

    // Direction, bytes per stream, idle cycles between bytes, burst expected before last byte
    typedef struct packed {
        int dir;
        int count;
        int gap;
        bit early;
    } row_t;

    logic     mode0_clk;
    logic     rst_n;
    uart_rx_t mcu_rx;
    uart_tx_t mcu_tx;
    logic     mcu_tx_idle = 1'b1;
    uart_rx_t node_rx;
    uart_tx_t node_tx;
    logic     node_tx_idle = 1'b1;
    logic     aux;

    row_t        rows [NUM_ROWS];
    logic [31:0] lfsr_state;
    int          cycle = 0;
    int          cycle_limit = 0;
    int          mismatch_count = 0;
    int          failure_count = 0;
    int          check_count = 0;
    int          node_uart_busy = 0;
    int          mcu_uart_busy = 0;
    bit          row_active = 1'b0;

    // Cycle stamps of the current row are -1 until seen
    int first_air_in = -1;
    int last_air_in = -1;
    int first_mcu_in = -1;
    int first_air_out = -1;
    int first_mcu_out = -1;
    int aux_low_at = -1;

    rf_byte_t exp_air[$];
    rf_byte_t got_air[$];
    rf_byte_t exp_mcu[$];
    rf_byte_t got_mcu[$];

    rf_transceiver_ctrl i_dut (
        .mode0_clk    (mode0_clk),
        .rst_n        (rst_n),
        .mcu_rx       (mcu_rx),
        .mcu_tx       (mcu_tx),
        .mcu_tx_idle  (mcu_tx_idle),
        .node_rx      (node_rx),
        .node_tx      (node_tx),
        .node_tx_idle (node_tx_idle),
        .aux          (aux)
    );

    always #50 mode0_clk = ~mode0_clk;

    function automatic logic [31:0] lfsr_next(input logic [31:0] s);
        logic [31:0] n;
        n = s >> 1;
        // Taps for x^32 + x^22 + x^2 + x + 1
        if (s[0]) begin
            n = n ^ 32'h8020_0003;
        end
        return n;
    endfunction

    task automatic draw_byte(output rf_byte_t b);
        b = '0;
        for (int i = 0; i < 8; i++) begin
            b = {b[6:0], lfsr_state[0]};
            lfsr_state = lfsr_next(lfsr_state);
        end
    endtask

    task automatic report_mismatch(input string msg);
        mismatch_count++;
        $display("Mismatch at %0t: %s", $time, msg);
    endtask

    task automatic compare_stream(input string name, input rf_byte_t exp_q[$],
                                  input rf_byte_t got_q[$]);
        check_count++;
        if (got_q.size() != exp_q.size()) begin
            report_mismatch($sformatf("%s carried %0d bytes, expected %0d",
                                      name, got_q.size(), exp_q.size()));
        end
        for (int i = 0; i < exp_q.size() && i < got_q.size(); i++) begin
            if (got_q[i] !== exp_q[i]) begin
                report_mismatch($sformatf("%s byte %0d is %02h, expected %02h",
                                          name, i, got_q[i], exp_q[i]));
            end
        end
    endtask

    // Input edge stamps and the first low aux of a row
    always @(posedge mode0_clk) begin
        cycle <= cycle + 1;
        if (rst_n) begin
            if (mcu_rx.valid) begin
                if (first_air_in < 0) begin
                    first_air_in = cycle;
                end
                last_air_in = cycle;
            end
            if (node_rx.valid && first_mcu_in < 0) begin
                first_mcu_in = cycle;
            end
            if (row_active && !aux && aux_low_at < 0) begin
                aux_low_at = cycle;
            end
        end
    end

    // Node UART stays busy for one byte time after each start
    always @(posedge mode0_clk) begin
        if (!rst_n) begin
            node_tx_idle   <= 1'b1;
            node_uart_busy <= 0;
        end else if (node_tx.start) begin
            if (!node_tx_idle) begin
                failure_count++;
                $display("Node UART got a start at %0t while still sending", $time);
            end
            got_air.push_back(node_tx.data);
            if (first_air_out < 0) begin
                first_air_out = cycle;
            end
            node_tx_idle   <= 1'b0;
            node_uart_busy <= UART_BYTE_CYCLES;
        end else if (node_uart_busy != 0) begin
            node_uart_busy <= node_uart_busy - 1;
            if (node_uart_busy == 1) begin
                node_tx_idle <= 1'b1;
            end
        end
    end

    // MCU UART behaves the same way
    always @(posedge mode0_clk) begin
        if (!rst_n) begin
            mcu_tx_idle   <= 1'b1;
            mcu_uart_busy <= 0;
        end else if (mcu_tx.start) begin
            if (!mcu_tx_idle) begin
                failure_count++;
                $display("MCU UART got a start at %0t while still sending", $time);
            end
            got_mcu.push_back(mcu_tx.data);
            if (first_mcu_out < 0) begin
                first_mcu_out = cycle;
            end
            mcu_tx_idle   <= 1'b0;
            mcu_uart_busy <= UART_BYTE_CYCLES;
        end else if (mcu_uart_busy != 0) begin
            mcu_uart_busy <= mcu_uart_busy - 1;
            if (mcu_uart_busy == 1) begin
                mcu_tx_idle <= 1'b1;
            end
        end
    end

    task automatic check_quiet(input int n);
        repeat (n) begin
            @(posedge mode0_clk);
            check_count++;
            if (!aux) begin
                report_mismatch("aux low with no traffic");
            end
            if (node_tx.start || mcu_tx.start) begin
                report_mismatch("start pulse with no traffic");
            end
        end
    endtask

    task automatic run_row(input row_t r);
        rf_byte_t b;
        int first_in;
        int settle;
        first_air_in  = -1;
        last_air_in   = -1;
        first_mcu_in  = -1;
        first_air_out = -1;
        first_mcu_out = -1;
        aux_low_at    = -1;
        row_active    = 1'b1;
        for (int i = 0; i < r.count; i++) begin
            @(posedge mode0_clk);
            if (r.dir != DIR_MCU) begin
                draw_byte(b);
                exp_air.push_back(b);
                mcu_rx <= '{valid: 1'b1, data: b};
            end
            if (r.dir != DIR_AIR) begin
                draw_byte(b);
                exp_mcu.push_back(b);
                node_rx <= '{valid: 1'b1, data: b};
            end
            @(posedge mode0_clk);
            mcu_rx  <= '0;
            node_rx <= '0;
            repeat (r.gap - 1) @(posedge mode0_clk);
        end
        // Every byte out and both UARTs finished
        @(negedge mode0_clk);
        while (got_air.size() < exp_air.size() || got_mcu.size() < exp_mcu.size() ||
               !node_tx_idle || !mcu_tx_idle) begin
            @(negedge mode0_clk);
        end
        settle = 0;
        while (!aux && settle < 3) begin
            @(negedge mode0_clk);
            settle++;
        end
        check_count++;
        if (!aux) begin
            report_mismatch("aux still low after the row completed");
        end
        // Catch stray bytes
        repeat (4) @(posedge mode0_clk);
        row_active = 1'b0;
        compare_stream("node_tx", exp_air, got_air);
        compare_stream("mcu_tx", exp_mcu, got_mcu);
        first_in = (first_air_in >= 0) ? first_air_in : first_mcu_in;
        check_count++;
        if (aux_low_at < 0 || aux_low_at - first_in > 2) begin
            report_mismatch($sformatf("aux low at cycle %0d, first byte at %0d",
                                      aux_low_at, first_in));
        end
        if (r.dir != DIR_MCU) begin
            check_count++;
            if (r.early && first_air_out >= last_air_in) begin
                report_mismatch("threshold did not start the burst before the last byte");
            end
            if (!r.early && first_air_out - last_air_in < `RF_TX_IDLE_CYCLES) begin
                report_mismatch($sformatf("burst started %0d cycles after the last byte",
                                          first_air_out - last_air_in));
            end
        end
        if (r.dir != DIR_AIR) begin
            check_count++;
            if (first_mcu_out - first_mcu_in < `RF_RX_HOLD_CYCLES) begin
                report_mismatch($sformatf("MCU output began %0d cycles after the first byte",
                                          first_mcu_out - first_mcu_in));
            end
        end
        exp_air.delete();
        got_air.delete();
        exp_mcu.delete();
        got_mcu.delete();
    endtask

    // Ends a hung run
    initial begin
        wait (cycle_limit != 0);
        while (cycle < cycle_limit) begin
            @(posedge mode0_clk);
        end
        $display("Run timed out after %0d cycles", cycle);
        $display("TESTS FAILED");
        $finish;
    end

    initial begin
        int limit;
        int n;
        mode0_clk  = 1'b0;
        rst_n      = 1'b0;
        mcu_rx     = '0;
        node_rx    = '0;
        lfsr_state = LFSR_SEED;
        rows[0] = '{DIR_AIR, 5, 3, 1'b0};
        rows[1] = '{DIR_AIR, 70, 2, 1'b1};
        rows[2] = '{DIR_MCU, 20, 4, 1'b0};
        rows[3] = '{DIR_BOTH, 12, 1, 1'b0};
        limit = 400;
        for (int i = 0; i < NUM_ROWS; i++) begin
            n = rows[i].count * (rows[i].gap + 12);
            if (rows[i].dir == DIR_BOTH) begin
                n = 2 * n;
            end
            limit = limit + n + `RF_TX_IDLE_CYCLES + `RF_RX_HOLD_CYCLES + 40;
        end
        cycle_limit = limit;
        repeat (2) @(posedge mode0_clk);
        rst_n <= 1'b1;
        check_quiet(20);
        for (int i = 0; i < NUM_ROWS; i++) begin
            run_row(rows[i]);
        end
        $display("Summary: %0d checks, %0d mismatches, %0d protocol errors",
                 check_count, mismatch_count, failure_count);
        if (mismatch_count == 0 && failure_count == 0) begin
            $display("TESTS PASSED");
        end else begin
            $display("TESTS FAILED");
        end
        $finish;
    end

endmodule
